// File: logic/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_ctrl import cache_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cpu_valid,
    output logic                     cpu_ready,
    input  req_kind_t                cpu_kind,
    input  logic [`CACHE_ADDR_W-1:0] cpu_addr,
    input  logic [`CACHE_WORD_W-1:0] cpu_wdata,
    output logic                     resp_valid,
    input  logic                     resp_ready,
    output logic [`CACHE_WORD_W-1:0] resp_rdata,
    output logic                     mem_req_valid,
    input  logic                     mem_req_ready,
    output logic                     mem_req_we,
    output logic [`CACHE_ADDR_W-1:0] mem_req_addr,
    output logic [`CACHE_WORD_W-1:0] mem_req_wdata,
    input  logic                     mem_resp_valid,
    input  logic [`CACHE_WORD_W-1:0] mem_resp_rdata,
    cache_store_if.master            store
);

    localparam int OFFS_W = `CACHE_ADDR_W - `CACHE_TAG_W - `CACHE_INDEX_W;

    ctrl_state_t state_q;
    logic        beat_q;
    logic        rd_ready_q;
    logic        fill_wait_q;

    // accepted request
    req_kind_t                req_kind_q;
    logic [`CACHE_ADDR_W-1:0] req_addr_q;
    logic [`CACHE_WORD_W-1:0] req_wdata_q;

    cache_line_t              line_q;
    logic [`CACHE_WORD_W-1:0] resp_data_q;

    logic [`CACHE_TAG_W-1:0]   req_tag;
    logic [`CACHE_INDEX_W-1:0] req_idx;
    logic                      hit;
    logic                      fill_last;
    cache_line_t               merged;
    logic [`CACHE_WORD_W-1:0]  rd_word;

    assign req_tag = req_addr_q[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign req_idx = req_addr_q[OFFS_W +: `CACHE_INDEX_W];
    assign fill_last = (state_q == ST_FILL) && fill_wait_q && mem_resp_valid && beat_q;

    always_comb begin
        hit = store.rd_line.valid && (store.rd_line.tag == req_tag);
        rd_word = store.rd_line.data[{req_addr_q[2], 5'b00000} +: `CACHE_WORD_W];
        merged = store.rd_line;
        merged.dirty = 1'b1;
        if (req_kind_q == REQ_WRITE_BYTE) begin
            merged.data[{req_addr_q[2:0], 3'b000} +: 8] = req_wdata_q[7:0];
        end else begin
            merged.data[{req_addr_q[2], 5'b00000} +: `CACHE_WORD_W] = req_wdata_q;
        end
    end

    // store port, merged write commits with the response handshake
    always_comb begin
        store.index = req_idx;
        store.wr_en = 1'b0;
        store.wr_line = line_q;
        if (state_q == ST_RESPOND && resp_ready && req_kind_q != REQ_READ) begin
            store.wr_en = 1'b1;
        end
        if (fill_last) begin
            store.wr_en = 1'b1;
            store.wr_line.valid = 1'b1;
            store.wr_line.dirty = 1'b0;
            store.wr_line.tag = req_tag;
            store.wr_line.data = {mem_resp_rdata, line_q.data[`CACHE_WORD_W-1:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            beat_q <= 1'b0;
            rd_ready_q <= 1'b0;
            fill_wait_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (cpu_valid) begin
                        state_q <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    // first cycle only waits for the registered read
                    rd_ready_q <= !rd_ready_q;
                    if (rd_ready_q) begin
                        if (hit) begin
                            state_q <= ST_RESPOND;
                        end else if (store.rd_line.valid && store.rd_line.dirty) begin
                            state_q <= ST_WRITE_BACK;
                        end else begin
                            state_q <= ST_FILL;
                        end
                    end
                end
                ST_WRITE_BACK: begin
                    if (mem_req_ready) begin
                        beat_q <= !beat_q;
                        if (beat_q) begin
                            state_q <= ST_FILL;
                        end
                    end
                end
                ST_FILL: begin
                    if (!fill_wait_q) begin
                        fill_wait_q <= mem_req_ready;
                    end else if (mem_resp_valid) begin
                        fill_wait_q <= 1'b0;
                        beat_q <= !beat_q;
                        if (beat_q) begin
                            state_q <= ST_LOOKUP;
                        end
                    end
                end
                ST_RESPOND: begin
                    if (resp_ready) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && cpu_valid) begin
            req_kind_q <= cpu_kind;
            req_addr_q <= cpu_addr;
            req_wdata_q <= cpu_wdata;
        end
        if (state_q == ST_LOOKUP && rd_ready_q) begin
            // victim on a miss, merged line on a hit
            line_q <= hit ? merged : store.rd_line;
            resp_data_q <= (hit && req_kind_q == REQ_READ) ? rd_word : '0;
        end
        if (state_q == ST_FILL && fill_wait_q && mem_resp_valid && !beat_q) begin
            line_q.data[`CACHE_WORD_W-1:0] <= mem_resp_rdata;
        end
    end

    assign cpu_ready = (state_q == ST_IDLE);
    assign resp_valid = (state_q == ST_RESPOND);
    assign resp_rdata = resp_data_q;

    assign mem_req_valid = (state_q == ST_WRITE_BACK) || (state_q == ST_FILL && !fill_wait_q);
    assign mem_req_we = (state_q == ST_WRITE_BACK);
    // victim tag on write-back, request tag on fill
    assign mem_req_addr = (state_q == ST_WRITE_BACK) ?
        {line_q.tag, req_idx, beat_q, 2'b00} : {req_tag, req_idx, beat_q, 2'b00};
    assign mem_req_wdata = (state_q != ST_WRITE_BACK) ? '0 :
        beat_q ? line_q.data[`CACHE_LINE_W-1 -: `CACHE_WORD_W] :
                 line_q.data[`CACHE_WORD_W-1:0];

endmodule

// File: logic/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// processor address
`define CACHE_ADDR_W 32

// direct-mapped geometry, 8-byte lines
`define CACHE_SETS 256
`define CACHE_INDEX_W 8
`define CACHE_TAG_W 21

// line and bus word
`define CACHE_LINE_W 64
`define CACHE_WORD_W 32

`endif

// File: logic/cache_pkg.sv
`include "cache_macros.svh"

package cache_pkg;

    // processor request kinds
    typedef enum logic [1:0] {
        REQ_READ       = 2'd0,
        REQ_WRITE_WORD = 2'd1,
        REQ_WRITE_BYTE = 2'd2
    } req_kind_t;

    // one stored line, flags above tag above data
    typedef struct packed {
        logic                     valid;
        logic                     dirty;
        logic [`CACHE_TAG_W-1:0]  tag;
        logic [`CACHE_LINE_W-1:0] data;
    } cache_line_t;

    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_LOOKUP     = 3'd1,
        ST_WRITE_BACK = 3'd2,
        ST_FILL       = 3'd3,
        ST_RESPOND    = 3'd4
    } ctrl_state_t;

endpackage

// File: logic/cache_store.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_store import cache_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    cache_store_if.slave  port
);

    logic [`CACHE_SETS-1:0]   valid_q;
    logic [`CACHE_SETS-1:0]   dirty_q;
    logic [`CACHE_TAG_W-1:0]  tag_mem  [`CACHE_SETS];
    logic [`CACHE_LINE_W-1:0] data_mem [`CACHE_SETS];
    cache_line_t              rd_q;

    // valid bits are the only state cleared by reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (port.wr_en) begin
            valid_q[port.index] <= port.wr_line.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            dirty_q[port.index]  <= port.wr_line.dirty;
            tag_mem[port.index]  <= port.wr_line.tag;
            data_mem[port.index] <= port.wr_line.data;
        end
    end

    // registered read, same-set write shows up next cycle
    always_ff @(posedge clk) begin
        rd_q.valid <= valid_q[port.index];
        rd_q.dirty <= dirty_q[port.index];
        rd_q.tag   <= tag_mem[port.index];
        rd_q.data  <= data_mem[port.index];
    end

    assign port.rd_line = rd_q;

endmodule

// File: logic/cache_store_if.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

interface cache_store_if import cache_pkg::*; ();

    logic [`CACHE_INDEX_W-1:0] index;
    logic                      wr_en;
    cache_line_t               wr_line;
    // line at last cycle's index
    cache_line_t               rd_line;

    modport master (
        output index,
        output wr_en,
        output wr_line,
        input  rd_line
    );

    modport slave (
        input  index,
        input  wr_en,
        input  wr_line,
        output rd_line
    );

endinterface

// File: logic/cache_top.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_top import cache_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cpu_valid,
    output logic                     cpu_ready,
    input  req_kind_t                cpu_kind,
    input  logic [`CACHE_ADDR_W-1:0] cpu_addr,
    input  logic [`CACHE_WORD_W-1:0] cpu_wdata,
    output logic                     resp_valid,
    input  logic                     resp_ready,
    output logic [`CACHE_WORD_W-1:0] resp_rdata,
    output logic                     mem_req_valid,
    input  logic                     mem_req_ready,
    output logic                     mem_req_we,
    output logic [`CACHE_ADDR_W-1:0] mem_req_addr,
    output logic [`CACHE_WORD_W-1:0] mem_req_wdata,
    input  logic                     mem_resp_valid,
    input  logic [`CACHE_WORD_W-1:0] mem_resp_rdata
);

    cache_store_if store_bus ();

    cache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .cpu_valid      (cpu_valid),
        .cpu_ready      (cpu_ready),
        .cpu_kind       (cpu_kind),
        .cpu_addr       (cpu_addr),
        .cpu_wdata      (cpu_wdata),
        .resp_valid     (resp_valid),
        .resp_ready     (resp_ready),
        .resp_rdata     (resp_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_we     (mem_req_we),
        .mem_req_addr   (mem_req_addr),
        .mem_req_wdata  (mem_req_wdata),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rdata (mem_resp_rdata),
        .store          (store_bus.master)
    );

    cache_store u_store (
        .clk  (clk),
        .rst  (rst),
        .port (store_bus.slave)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# builds the cache testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f vlog.f --top-module cache_tb \
    -Mdir obj_dir -o cache_sim \
    && ./obj_dir/cache_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error"

cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1

// File: sim/cache_chk.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_chk import cache_pkg::*; (
    input logic                     clk,
    input logic                     rst,
    input logic                     cpu_ready,
    input logic                     resp_valid,
    input logic                     resp_ready,
    input logic [`CACHE_WORD_W-1:0] resp_rdata,
    input logic                     mem_req_valid,
    input logic                     mem_req_ready,
    input logic                     mem_req_we,
    input logic [`CACHE_ADDR_W-1:0] mem_req_addr,
    input logic [`CACHE_WORD_W-1:0] mem_req_wdata,
    input ctrl_state_t              state
);

    // one request in flight at most
    ready_resp_excl: assert property (@(posedge clk) disable iff (rst)
        !(cpu_ready && resp_valid))
        else $error("cpu_ready and resp_valid are high together");

    resp_stable: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata))
        else $error("response changed under back-pressure");

    mem_req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=>
            mem_req_valid && $stable({mem_req_we, mem_req_addr, mem_req_wdata}))
        else $error("memory request changed before it was accepted");

    reset_state: assert property (@(posedge clk)
        rst |=> !mem_req_valid && state == ST_IDLE)
        else $error("controller not idle after reset");

endmodule

// File: sim/cache_scoreboard.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_scoreboard import cache_pkg::*; (
    input logic                     clk,
    input logic                     rst,
    input logic                     cpu_valid,
    input logic                     cpu_ready,
    input req_kind_t                cpu_kind,
    input logic [`CACHE_ADDR_W-1:0] cpu_addr,
    input logic [`CACHE_WORD_W-1:0] cpu_wdata,
    input logic                     resp_valid,
    input logic                     resp_ready,
    input logic [`CACHE_WORD_W-1:0] resp_rdata,
    input logic                     mem_req_valid,
    input logic                     mem_req_ready,
    input logic                     mem_req_we,
    input logic [`CACHE_ADDR_W-1:0] mem_req_addr,
    input logic [`CACHE_WORD_W-1:0] mem_req_wdata,
    input logic                     mem_resp_valid,
    input logic [`CACHE_WORD_W-1:0] mem_resp_rdata
);

    int errors = 0;
    int accepted = 0;
    int responses = 0;

    logic [31:0]             shadow [logic [31:0]];
    logic [`CACHE_SETS-1:0]  line_valid;
    logic                    line_dirty [`CACHE_SETS];
    logic [`CACHE_TAG_W-1:0] line_tag [`CACHE_SETS];
    logic [31:0]             exp_data;
    logic [31:0]             req_line;
    logic [31:0]             victim_line;
    logic                    hit_exp;
    logic                    req_read;
    logic                    resp_seen;
    int exp_rd;
    int exp_wb;
    int seen_rd;
    int seen_wb;
    int seen_resp;
    int cycle = 0;
    int acc_cycle = 0;

    // same fill pattern as the memory model
    function automatic logic [31:0] initial_word(logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'd3) ^ 32'h5bd1_e995;
    endfunction

    function automatic logic [31:0] shadow_word(logic [31:0] a);
        return shadow.exists(a) ? shadow[a] : initial_word(a);
    endfunction

    // expected response word, writes answer zero
    function automatic logic [31:0] expected_rdata(req_kind_t kind, logic [31:0] a);
        return (kind == REQ_READ) ? shadow_word({a[31:2], 2'b00}) : 32'h0;
    endfunction

    function automatic logic [31:0] merge_write(logic [31:0] old, req_kind_t kind,
                                                logic [31:0] a, logic [31:0] wdata);
        logic [31:0] w;
        w = old;
        if (kind == REQ_WRITE_BYTE) begin
            w[{a[1:0], 3'b000} +: 8] = wdata[7:0];
        end else if (kind == REQ_WRITE_WORD) begin
            w = wdata;
        end
        return w;
    endfunction

    task automatic report(string name, logic [31:0] exp, logic [31:0] act);
        errors++;
        $display("error %s: expected %h, actual %h", name, exp, act);
    endtask

    always @(posedge clk) begin
        logic [7:0]  set;
        logic [20:0] tag;
        logic [31:0] wa;
        logic [31:0] fa;
        if (rst) begin
            line_valid = '0;
            resp_seen = 1'b1;
        end else begin
            if (cpu_valid && cpu_ready) begin
                set = cpu_addr[10:3];
                tag = cpu_addr[31:11];
                wa = {cpu_addr[31:2], 2'b00};
                hit_exp = line_valid[set] && line_tag[set] == tag;
                exp_rd = hit_exp ? 0 : 2;
                exp_wb = (!hit_exp && line_valid[set] && line_dirty[set]) ? 2 : 0;
                victim_line = {line_tag[set], set, 3'b000};
                req_line = {tag, set, 3'b000};
                req_read = (cpu_kind == REQ_READ);
                exp_data = expected_rdata(cpu_kind, cpu_addr);
                shadow[wa] = merge_write(shadow_word(wa), cpu_kind, cpu_addr, cpu_wdata);
                line_dirty[set] = (hit_exp && line_dirty[set]) || cpu_kind != REQ_READ;
                line_valid[set] = 1'b1;
                line_tag[set] = tag;
                seen_rd = 0;
                seen_wb = 0;
                seen_resp = 0;
                acc_cycle = cycle;
                resp_seen = 1'b0;
                accepted++;
            end
            if (mem_req_valid && mem_req_ready && mem_req_we) begin
                if (seen_wb >= exp_wb) begin
                    errors++;
                    $display("write-back beat to %h for a line that is not dirty", mem_req_addr);
                end
                if (mem_req_addr != victim_line + seen_wb * 4)
                    report("write-back address", victim_line + seen_wb * 4, mem_req_addr);
                if (mem_req_wdata != shadow_word(victim_line + seen_wb * 4))
                    report("write-back data", shadow_word(victim_line + seen_wb * 4),
                           mem_req_wdata);
                seen_wb++;
            end else if (mem_req_valid && mem_req_ready) begin
                if (seen_wb != exp_wb) begin
                    errors++;
                    $display("fill read at %h issued before the write-back ended", mem_req_addr);
                end
                if (mem_req_addr != req_line + seen_rd * 4)
                    report("fill address", req_line + seen_rd * 4, mem_req_addr);
                seen_rd++;
            end
            // a missed line is up to date in memory
            if (mem_resp_valid) begin
                fa = req_line + seen_resp * 4;
                if (req_read && mem_resp_rdata != shadow_word(fa))
                    report("fill data", shadow_word(fa), mem_resp_rdata);
                seen_resp++;
            end
            // hit responds two cycles after acceptance
            if (resp_valid && !resp_seen) begin
                resp_seen = 1'b1;
                if (hit_exp && cycle - acc_cycle != 3)
                    report("hit latency", 32'd2, cycle - acc_cycle - 1);
            end
            if (resp_valid && resp_ready) begin
                responses++;
                if (resp_rdata != exp_data)
                    report("response data", exp_data, resp_rdata);
                if (seen_rd != exp_rd)
                    report("fill beat count", exp_rd, seen_rd);
                if (seen_resp != exp_rd)
                    report("memory response count", exp_rd, seen_resp);
                if (seen_wb != exp_wb)
                    report("write-back beat count", exp_wb, seen_wb);
            end
        end
        cycle++;
    end

endmodule

// File: sim/cache_tb.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_tb import cache_pkg::*; ();

    localparam int          NUM_REQ = 600;
    localparam int          CYCLES_PER_REQ = 40;
    localparam int          MAX_LAT = 5;
    localparam int unsigned SEED = 32'h985a5f0c;

    logic        clk = 1'b0;
    logic        rst;
    logic        cpu_valid;
    logic        cpu_ready;
    req_kind_t   cpu_kind;
    logic [31:0] cpu_addr;
    logic [31:0] cpu_wdata;
    logic        resp_valid;
    logic        resp_ready = 1'b0;
    logic [31:0] resp_rdata;
    logic        mem_req_valid;
    logic        mem_req_ready = 1'b0;
    logic        mem_req_we;
    logic [31:0] mem_req_addr;
    logic [31:0] mem_req_wdata;
    logic        mem_resp_valid = 1'b0;
    logic [31:0] mem_resp_rdata = 32'h0;

    // memory model state
    logic [31:0] mem [logic [31:0]];
    logic        pend = 1'b0;
    logic [31:0] pend_addr;
    int          pend_cnt;

    cache_top u_dut (.*);

    cache_scoreboard u_sb (.*);

    bind cache_ctrl cache_chk u_chk (
        .clk           (clk),
        .rst           (rst),
        .cpu_ready     (cpu_ready),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .resp_rdata    (resp_rdata),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_we    (mem_req_we),
        .mem_req_addr  (mem_req_addr),
        .mem_req_wdata (mem_req_wdata),
        .state         (state_q)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] hash_word(logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'd3) ^ 32'h5bd1_e995;
    endfunction

    function automatic logic [31:0] read_word(logic [31:0] a);
        return mem.exists(a) ? mem[a] : hash_word(a);
    endfunction

    // 4 tags x 4 sets x 2 words, byte offset random
    function automatic logic [31:0] pick_addr();
        logic [20:0] tag;
        logic [7:0]  set;
        tag = 21'h1a0 + 21'($urandom_range(3));
        set = 8'h40 + 8'($urandom_range(3)) * 8'd23;
        return {tag, set, 1'($urandom_range(1)), 2'($urandom_range(3))};
    endfunction

    // accept decided here, response a random number of cycles later
    always @(negedge clk) begin
        mem_resp_valid = 1'b0;
        if (rst) begin
            pend = 1'b0;
            mem_req_ready = 1'b0;
            resp_ready = 1'b0;
        end else begin
            if (pend && pend_cnt == 0) begin
                mem_resp_valid = 1'b1;
                mem_resp_rdata = read_word(pend_addr);
                pend = 1'b0;
            end else if (pend) begin
                pend_cnt--;
            end
            mem_req_ready = ($urandom_range(2) != 0);
            if (mem_req_valid && mem_req_ready && mem_req_we) begin
                mem[mem_req_addr] = mem_req_wdata;
            end else if (mem_req_valid && mem_req_ready) begin
                pend = 1'b1;
                pend_addr = mem_req_addr;
                pend_cnt = $urandom_range(MAX_LAT);
            end
            resp_ready = ($urandom_range(3) != 0);
        end
    end

    initial begin
        int unsigned seed_val;
        logic [31:0] addr;
        seed_val = $urandom(SEED);
        rst = 1'b1;
        cpu_valid = 1'b0;
        cpu_kind = REQ_READ;
        cpu_addr = '0;
        cpu_wdata = '0;
        addr = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < NUM_REQ; i++) begin
            // a repeat of the last address is a read, to exercise hits
            if (i == 0 || $urandom_range(3) != 0) begin
                addr = pick_addr();
                cpu_kind = req_kind_t'(2'($urandom_range(2)));
            end else begin
                cpu_kind = REQ_READ;
            end
            cpu_valid = 1'b1;
            cpu_addr = addr;
            cpu_wdata = $urandom;
            while (!cpu_ready) @(negedge clk);
            @(negedge clk);
            cpu_valid = 1'b0;
        end
        wait (u_sb.responses == NUM_REQ);
        repeat (4) @(negedge clk);
        $display("errors: %0d  accepted: %0d  responses: %0d",
                 u_sb.errors, u_sb.accepted, u_sb.responses);
        if (u_sb.errors == 0 && u_sb.accepted == u_sb.responses) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(NUM_REQ * CYCLES_PER_REQ * 8);
        $display("timeout: the requests did not all complete in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+logic
logic/cache_pkg.sv
logic/cache_store_if.sv
logic/cache_store.sv
logic/cache_ctrl.sv
logic/cache_top.sv
sim/cache_chk.sv
sim/cache_scoreboard.sv
sim/cache_tb.sv
